/* logic/riscPipe_settings.svh */
`ifndef RISCPIPE_SETTINGS_SVH
`define RISCPIPE_SETTINGS_SVH

// data path and address width
`define XLEN 32

// register index width for 32 architectural registers
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* logic/riscPipePkg.sv */
`default_nettype none

`include "riscPipe_settings.svh"

package riscPipePkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } aluOpE;

    typedef enum logic {OP1_RS1, OP1_PC} op1SelE;
    typedef enum logic {OP2_RS2, OP2_IMM} op2SelE;
    typedef enum logic {PC_PLUS4, PC_TARGET} pcSelE;

    // link is pc+4 of the instruction itself
    typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_MEM} wbSelE;

    // all zero means bubble
    typedef struct packed {
        aluOpE                   aluOp;
        op1SelE                  op1Sel;
        op2SelE                  op2Sel;
        wbSelE                   wbSel;
        logic                    isBranch;
        logic                    isBne;
        logic                    isJump;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic [`REG_ADDR_W-1:0]  rd;
    } ctrlWordT;

endpackage

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscPipe_settings.svh"

module instrDecoder
    import riscPipePkg::*;
(
    input  wire [`XLEN-1:0] instruction,
    output ctrlWordT        ctrl,
    output logic [`XLEN-1:0] imm
);

    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;

    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // sign extended immediates per format
    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcodeE'(instruction[6:0]))
            OPC_OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.rd       = instruction[11:7];
                case (funct3)
                    3'b000:  ctrl.aluOp = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.aluOp = ALU_SLT;
                    3'b100:  ctrl.aluOp = ALU_XOR;
                    3'b110:  ctrl.aluOp = ALU_OR;
                    3'b111:  ctrl.aluOp = ALU_AND;
                    // shifts and sltu are not supported
                    default: ctrl = '0;
                endcase
            end
            OPC_OP_IMM: begin
                // only addi
                if (funct3 == 3'b000) begin
                    ctrl.op2Sel   = OP2_IMM;
                    ctrl.regWrite = 1'b1;
                    ctrl.rd       = instruction[11:7];
                    imm           = immI;
                end
            end
            OPC_LUI: begin
                ctrl.aluOp    = ALU_PASS_B;
                ctrl.op2Sel   = OP2_IMM;
                ctrl.regWrite = 1'b1;
                ctrl.rd       = instruction[11:7];
                imm           = immU;
            end
            OPC_LOAD: begin
                ctrl.op2Sel   = OP2_IMM;
                ctrl.wbSel    = WB_MEM;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.rd       = instruction[11:7];
                imm           = immI;
            end
            OPC_STORE: begin
                ctrl.op2Sel   = OP2_IMM;
                ctrl.memWrite = 1'b1;
                imm           = immS;
            end
            OPC_BRANCH: begin
                // beq and bne only, compare runs on op1 against rs2
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl.op2Sel   = OP2_IMM;
                    ctrl.isBranch = 1'b1;
                    ctrl.isBne    = funct3[0];
                    imm           = immB;
                end
            end
            OPC_JAL: begin
                ctrl.op1Sel   = OP1_PC;
                ctrl.op2Sel   = OP2_IMM;
                ctrl.wbSel    = WB_LINK;
                ctrl.isJump   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.rd       = instruction[11:7];
                imm           = immJ;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscPipe_settings.svh"

module regFile
    import riscPipePkg::*;
(
    input  wire                    clk,
    input  wire                    arstN,
    input  wire [`REG_ADDR_W-1:0]  rs1Addr,
    input  wire [`REG_ADDR_W-1:0]  rs2Addr,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data,
    input  wire [`REG_ADDR_W-1:0]  writeAddr,
    input  wire [`XLEN-1:0]        writeData,
    input  wire                    writeEnable,
    input  wire [`REG_ADDR_W-1:0]  debugRegAddr,
    output logic [`XLEN-1:0]       debugRegData
);

    localparam int regCount = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [regCount];

    // x0 is never written, so it stays zero from reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign rs1Data      = regs[rs1Addr];
    assign rs2Data      = regs[rs2Addr];
    assign debugRegData = regs[debugRegAddr];

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscPipe_settings.svh"

module hazardUnit
    import riscPipePkg::*;
(
    input  wire [`REG_ADDR_W-1:0] rs1Addr,
    input  wire [`REG_ADDR_W-1:0] rs2Addr,
    input  wire ctrlWordT         decodeCtrl,
    input  wire ctrlWordT         executeCtrl,
    input  wire ctrlWordT         memoryCtrl,
    input  wire ctrlWordT         writebackCtrl,
    input  wire                   branchTaken,
    output logic                  pcWriteEnable,
    output logic                  fetchKill,
    output logic                  decodeKill
);

    logic stall;

    // pending write of one in-flight word to a source register
    function automatic logic pendingWrite(input ctrlWordT word,
                                          input logic [`REG_ADDR_W-1:0] src);
        return word.regWrite && src != '0 && word.rd == src;
    endfunction

    always_comb begin
        stall = 1'b0;
        for (int s = 0; s < 2; s++) begin
            stall |= pendingWrite(decodeCtrl,    s == 0 ? rs1Addr : rs2Addr);
            stall |= pendingWrite(executeCtrl,   s == 0 ? rs1Addr : rs2Addr);
            stall |= pendingWrite(memoryCtrl,    s == 0 ? rs1Addr : rs2Addr);
            stall |= pendingWrite(writebackCtrl, s == 0 ? rs1Addr : rs2Addr);
        end
    end

    // a taken branch flushes both younger slots and wins over a stall
    assign pcWriteEnable = branchTaken || !stall;
    assign fetchKill     = branchTaken || stall;
    assign decodeKill    = branchTaken;

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscPipe_settings.svh"

module executeUnit
    import riscPipePkg::*;
(
    input  wire ctrlWordT         ctrl,
    input  wire [`XLEN-1:0]       pcValue,
    input  wire [`XLEN-1:0]       op1,
    input  wire [`XLEN-1:0]       op2,
    input  wire [`XLEN-1:0]       rs2Value,
    output logic [`XLEN-1:0]      aluResult,
    output logic [`XLEN-1:0]      target,
    output logic                  branchTaken
);

    logic  isEqual;
    pcSelE pcSel;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:    aluResult = op1 + op2;
            ALU_SUB:    aluResult = op1 - op2;
            ALU_AND:    aluResult = op1 & op2;
            ALU_OR:     aluResult = op1 | op2;
            ALU_XOR:    aluResult = op1 ^ op2;
            ALU_SLT:    aluResult = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_PASS_B: aluResult = op2;
            default:    aluResult = '0;
        endcase
    end

    // branches carry the offset in op2 and rs1 in op1
    assign isEqual = op1 == rs2Value;
    assign target  = pcValue + op2;

    always_comb begin
        pcSel = PC_PLUS4;
        if (ctrl.isJump || (ctrl.isBranch && (isEqual ^ ctrl.isBne))) begin
            pcSel = PC_TARGET;
        end
    end

    assign branchTaken = pcSel == PC_TARGET;

endmodule

`default_nettype wire

/* logic/riscPipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscPipe_settings.svh"

module riscPipeCore
    import riscPipePkg::*;
(
    input  wire                   clk,
    input  wire                   arstN,
    output logic [`XLEN-1:0]      pc,
    input  wire [`XLEN-1:0]       instruction,
    output logic [`XLEN-1:0]      memoryAddress,
    output logic [`XLEN-1:0]      memoryWriteData,
    output logic                  memoryReadEnable,
    output logic                  memoryWriteEnable,
    input  wire [`XLEN-1:0]       memoryReadData,
    input  wire [`REG_ADDR_W-1:0] debugRegAddr,
    output logic [`XLEN-1:0]      debugRegData
);

    logic pcWriteEnable;
    logic fetchKill;
    logic decodeKill;
    logic branchTaken;

    logic [`XLEN-1:0] decInstr, decPc, decImm, rs1Data, rs2Data;
    logic             decValid;
    ctrlWordT         decCtrlRaw, decCtrl;

    logic [`XLEN-1:0] exePc, exeOp1, exeOp2, exeRs2, aluResult, target;
    ctrlWordT         exeCtrl;

    logic [`XLEN-1:0] memPc, memAluResult, memRs2, wbDataNext, wbData;
    ctrlWordT         memCtrl, wbCtrl;

    // fetch
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (pcWriteEnable) begin
            pc <= branchTaken ? target : pc + 4;
        end
    end

    // killed or stalled fetches enter decode as a nop
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decInstr <= `NOP_INSTR;
            decValid <= 1'b0;
        end else begin
            decInstr <= fetchKill ? `NOP_INSTR : instruction;
            decValid <= !fetchKill;
        end
    end

    always_ff @(posedge clk) begin
        decPc <= pc;
    end

    hazardUnit hazardUnit_i (
        .rs1Addr       (instruction[19:15]),
        .rs2Addr       (instruction[24:20]),
        .decodeCtrl    (decCtrl),
        .executeCtrl   (exeCtrl),
        .memoryCtrl    (memCtrl),
        .writebackCtrl (wbCtrl),
        .branchTaken   (branchTaken),
        .pcWriteEnable (pcWriteEnable),
        .fetchKill     (fetchKill),
        .decodeKill    (decodeKill)
    );

    // decode
    instrDecoder instrDecoder_i (
        .instruction (decInstr),
        .ctrl        (decCtrlRaw),
        .imm         (decImm)
    );

    assign decCtrl = decValid ? decCtrlRaw : '0;

    regFile regFile_i (
        .clk          (clk),
        .arstN        (arstN),
        .rs1Addr      (decInstr[19:15]),
        .rs2Addr      (decInstr[24:20]),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .writeAddr    (wbCtrl.rd),
        .writeData    (wbData),
        .writeEnable  (wbCtrl.regWrite),
        .debugRegAddr (debugRegAddr),
        .debugRegData (debugRegData)
    );

    always_ff @(posedge clk) begin
        exePc  <= decPc;
        exeOp1 <= decCtrl.op1Sel == OP1_PC ? decPc : rs1Data;
        exeOp2 <= decCtrl.op2Sel == OP2_IMM ? decImm : rs2Data;
        exeRs2 <= rs2Data;
    end

    // execute, memory and writeback control words
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exeCtrl <= '0;
            memCtrl <= '0;
            wbCtrl  <= '0;
        end else begin
            exeCtrl <= decodeKill ? '0 : decCtrl;
            memCtrl <= exeCtrl;
            wbCtrl  <= memCtrl;
        end
    end

    executeUnit executeUnit_i (
        .ctrl        (exeCtrl),
        .pcValue     (exePc),
        .op1         (exeOp1),
        .op2         (exeOp2),
        .rs2Value    (exeRs2),
        .aluResult   (aluResult),
        .target      (target),
        .branchTaken (branchTaken)
    );

    always_ff @(posedge clk) begin
        memPc        <= exePc;
        memAluResult <= aluResult;
        memRs2       <= exeRs2;
    end

    // memory stage with the RAM answering in the same cycle
    assign memoryAddress     = memAluResult;
    assign memoryWriteData   = memRs2;
    assign memoryReadEnable  = memCtrl.memRead;
    assign memoryWriteEnable = memCtrl.memWrite;

    always_comb begin
        case (memCtrl.wbSel)
            WB_LINK: wbDataNext = memPc + 4;
            WB_MEM:  wbDataNext = memoryReadData;
            default: wbDataNext = memAluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        wbData <= wbDataNext;
    end

endmodule

`default_nettype wire

/* testbench/riscPipe_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscPipe_settings.svh"

module riscPipe_props (
    input wire             clk,
    input wire             arstN,
    input wire [`XLEN-1:0] pc,
    input wire [`XLEN-1:0] memoryAddress,
    input wire             memoryReadEnable,
    input wire             memoryWriteEnable
);

    // failed assertions so far
    int failureCount = 0;

    memPortExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(memoryReadEnable && memoryWriteEnable))
        else begin
            failureCount++;
            $error("memory read and write enables are high together");
        end

    pcWordAligned: assert property (@(posedge clk) disable iff (!arstN)
        pc[1:0] == 2'b00)
        else begin
            failureCount++;
            $error("pc is not word aligned");
        end

    // only word stores exist
    storeWordAligned: assert property (@(posedge clk) disable iff (!arstN)
        memoryWriteEnable |-> memoryAddress[1:0] == 2'b00)
        else begin
            failureCount++;
            $error("store address is not word aligned");
        end

endmodule

bind riscPipeCore riscPipe_props props_i (
    .clk               (clk),
    .arstN             (arstN),
    .pc                (pc),
    .memoryAddress     (memoryAddress),
    .memoryReadEnable  (memoryReadEnable),
    .memoryWriteEnable (memoryWriteEnable)
);

`default_nettype wire

/* testbench/riscPipeTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscPipe_settings.svh"

module riscPipeTb;

    localparam int progLength = 40;
    localparam int haltIndex  = progLength;
    localparam int romDepth   = 64;
    localparam int ramDepth   = 16;
    localparam int waitLimit  = 2000;
    localparam logic [`XLEN-1:0] haltAddr = `RESET_PC + haltIndex * 4;

    typedef enum logic [3:0] {
        KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_XOR, KIND_SLT, KIND_ADDI,
        KIND_LUI, KIND_LW, KIND_SW, KIND_BEQ, KIND_BNE, KIND_JAL
    } instrKindE;

    typedef struct packed {
        instrKindE              kind;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;
    } progEntryT;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } storeT;

    logic                   clk;
    logic                   arstN;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       instruction;
    logic [`XLEN-1:0]       memoryAddress;
    logic [`XLEN-1:0]       memoryWriteData;
    logic                   memoryReadEnable;
    logic                   memoryWriteEnable;
    logic [`XLEN-1:0]       memoryReadData;
    logic [`REG_ADDR_W-1:0] debugRegAddr;
    logic [`XLEN-1:0]       debugRegData;

    logic [`XLEN-1:0] rom [romDepth];
    logic [`XLEN-1:0] ram [ramDepth];
    logic [`XLEN-1:0] romIndex;
    progEntryT        progEntries [progLength];
    logic [`XLEN-1:0] modelRegs [32];
    logic [`XLEN-1:0] modelMem [ramDepth];
    storeT            expectedStores [$];
    int               modelStoreCount;
    int               storeCount;
    integer           seed;

    // RAM write seen at negedge and applied after the next rising edge
    logic             writePending;
    logic [3:0]       writeIndex;
    logic [`XLEN-1:0] writeValue;

    riscPipeCore riscPipeCore_i (
        .clk               (clk),
        .arstN             (arstN),
        .pc                (pc),
        .instruction       (instruction),
        .memoryAddress     (memoryAddress),
        .memoryWriteData   (memoryWriteData),
        .memoryReadEnable  (memoryReadEnable),
        .memoryWriteEnable (memoryWriteEnable),
        .memoryReadData    (memoryReadData),
        .debugRegAddr      (debugRegAddr),
        .debugRegData      (debugRegData)
    );

    always #10 clk = ~clk;

    // combinational ROM and RAM
    // fetches past the ROM return a nop
    assign romIndex       = (pc - `RESET_PC) >> 2;
    assign instruction    = romIndex < romDepth ? rom[romIndex[5:0]] : `NOP_INSTR;
    // read data only exists while the core reads
    assign memoryReadData = memoryReadEnable === 1'b1 ? ram[memoryAddress[5:2]] : 'x;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // initial RAM contents as a function of the whole byte address
    function automatic logic [31:0] ramFill(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] encode(input progEntryT e);
        case (e.kind)
            KIND_ADD:  return {7'b0000000, e.rs2, e.rs1, 3'b000, e.rd, 7'b0110011};
            KIND_SUB:  return {7'b0100000, e.rs2, e.rs1, 3'b000, e.rd, 7'b0110011};
            KIND_AND:  return {7'b0000000, e.rs2, e.rs1, 3'b111, e.rd, 7'b0110011};
            KIND_OR:   return {7'b0000000, e.rs2, e.rs1, 3'b110, e.rd, 7'b0110011};
            KIND_XOR:  return {7'b0000000, e.rs2, e.rs1, 3'b100, e.rd, 7'b0110011};
            KIND_SLT:  return {7'b0000000, e.rs2, e.rs1, 3'b010, e.rd, 7'b0110011};
            KIND_ADDI: return {e.imm[11:0], e.rs1, 3'b000, e.rd, 7'b0010011};
            KIND_LUI:  return {e.imm[31:12], e.rd, 7'b0110111};
            KIND_LW:   return {e.imm[11:0], e.rs1, 3'b010, e.rd, 7'b0000011};
            KIND_SW:   return {e.imm[11:5], e.rs2, e.rs1, 3'b010, e.imm[4:0], 7'b0100011};
            KIND_BEQ:  return {e.imm[12], e.imm[10:5], e.rs2, e.rs1, 3'b000,
                               e.imm[4:1], e.imm[11], 7'b1100011};
            KIND_BNE:  return {e.imm[12], e.imm[10:5], e.rs2, e.rs1, 3'b001,
                               e.imm[4:1], e.imm[11], 7'b1100011};
            default:   return {e.imm[20], e.imm[10:1], e.imm[11], e.imm[19:12],
                               e.rd, 7'b1101111};
        endcase
    endfunction

    task automatic generateProgram();
        logic [31:0] r;
        int          i;
        int          target;
        progEntryT   e;
        for (i = 0; i < romDepth; i++) begin
            rom[i] = `NOP_INSTR;
        end
        for (i = 0; i < ramDepth; i++) begin
            ram[i] = ramFill(i * 4);
        end
        for (i = 0; i < progLength; i++) begin
            r = $random(seed);
            e.kind = instrKindE'(r % 13);
            r = $random(seed);
            e.rd  = {2'b00, r[2:0]};
            e.rs1 = {2'b00, r[5:3]};
            e.rs2 = {2'b00, r[8:6]};
            // first instruction always writes x0
            if (i == 0) begin
                e.kind = KIND_ADDI;
                e.rd   = '0;
            end
            r = $random(seed);
            case (e.kind)
                KIND_ADDI: e.imm = {{20{r[11]}}, r[11:0]};
                KIND_LUI:  e.imm = {r[19:0], 12'h000};
                KIND_LW, KIND_SW: begin
                    e.rs1 = '0;
                    e.imm = {26'b0, r[3:0], 2'b00};
                end
                KIND_BEQ, KIND_BNE, KIND_JAL: begin
                    // forward only and never past the halt
                    target = i + 1 + r[1:0];
                    if (target > haltIndex) begin
                        target = haltIndex;
                    end
                    e.imm = (target - i) * 4;
                end
                default: e.imm = '0;
            endcase
            progEntries[i] = e;
            rom[i] = encode(e);
        end
        // jal x0, 0 spins on itself
        e = '0;
        e.kind = KIND_JAL;
        rom[haltIndex] = encode(e);
    endtask

    task automatic runModel();
        int          idx;
        int          next;
        int          steps;
        int          i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] result;
        logic        writes;
        progEntryT   e;
        for (i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (i = 0; i < ramDepth; i++) begin
            modelMem[i] = ramFill(i * 4);
        end
        idx = 0;
        steps = 0;
        modelStoreCount = 0;
        while (idx != haltIndex && steps < 1000) begin
            e = progEntries[idx];
            a = modelRegs[e.rs1];
            b = modelRegs[e.rs2];
            addr = a + e.imm;
            next = idx + 1;
            writes = 1'b1;
            result = '0;
            case (e.kind)
                KIND_ADD:  result = a + b;
                KIND_SUB:  result = a - b;
                KIND_AND:  result = a & b;
                KIND_OR:   result = a | b;
                KIND_XOR:  result = a ^ b;
                KIND_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                KIND_ADDI: result = a + e.imm;
                KIND_LUI:  result = e.imm;
                KIND_LW:   result = modelMem[addr[5:2]];
                KIND_SW: begin
                    writes = 1'b0;
                    expectedStores.push_back({addr, b});
                    modelMem[addr[5:2]] = b;
                    modelStoreCount++;
                end
                KIND_BEQ, KIND_BNE: begin
                    writes = 1'b0;
                    if ((a == b) == (e.kind == KIND_BEQ)) begin
                        next = idx + e.imm / 4;
                    end
                end
                default: begin
                    result = `RESET_PC + idx * 4 + 4;
                    next = idx + e.imm / 4;
                end
            endcase
            if (writes) begin
                modelRegs[e.rd] = result;
            end
            modelRegs[0] = '0;
            idx = next;
            steps++;
        end
        if (idx != haltIndex) begin
            abortRun("the reference model did not reach the halt instruction");
        end
    endtask

    task automatic checkResetState();
        checkValue("pc", pc, `RESET_PC);
        checkValue("memoryReadEnable", memoryReadEnable, 1'b0);
        checkValue("memoryWriteEnable", memoryWriteEnable, 1'b0);
    endtask

    // halt jumps to itself, so pc runs halt, +4, +8 and back;
    // on the third visit nothing older is left in flight
    task automatic waitForHalt();
        int cycles;
        int visits;
        cycles = 0;
        visits = 0;
        while (visits < 3 && cycles < waitLimit) begin
            @(negedge clk);
            if (pc == haltAddr) begin
                visits++;
            end
            cycles++;
        end
        if (visits < 3) begin
            abortRun("Timeout: pc did not reach the halt address");
        end
    endtask

    // stores in program order against the model
    always @(negedge clk) begin
        if (arstN === 1'b1 && memoryWriteEnable === 1'b1) begin
            if (expectedStores.size() == 0) begin
                abortRun("the core stored more often than the reference model");
            end
            checkValue("memoryAddress", memoryAddress, expectedStores[0].addr);
            checkValue("memoryWriteData", memoryWriteData, expectedStores[0].data);
            void'(expectedStores.pop_front());
            storeCount++;
            writePending = 1'b1;
            writeIndex   = memoryAddress[5:2];
            writeValue   = memoryWriteData;
        end
    end

    always @(posedge clk) begin
        #1;
        if (writePending) begin
            ram[writeIndex] = writeValue;
            writePending = 1'b0;
        end
    end

    // a failed bound assertion ends the run at once
    always @(negedge clk) begin
        if (riscPipeCore_i.props_i.failureCount != 0) begin
            abortRun("a bound assertion on the core ports failed");
        end
    end

    initial begin
        seed = 32'hb73e_7321;
        clk = 1'b0;
        arstN = 1'b0;
        debugRegAddr = '0;
        writePending = 1'b0;
        writeIndex = '0;
        writeValue = '0;
        storeCount = 0;
        generateProgram();
        runModel();

        repeat (2) begin
            @(posedge clk);
            #1;
            checkResetState();
        end
        arstN = 1'b1;
        @(negedge clk);
        checkResetState();

        waitForHalt();
        checkValue("store count", storeCount, modelStoreCount);

        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            #1;
            debugRegAddr = 5'(r);
            @(negedge clk);
            checkValue($sformatf("debugRegData[x%0d]", r), debugRegData, modelRegs[r]);
        end
        @(posedge clk);
        #1;
        debugRegAddr = '0;
        @(negedge clk);
        checkValue("debugRegData[x0]", debugRegData, 32'h0);

        if (riscPipeCore_i.props_i.failureCount != 0) begin
            abortRun("a bound assertion on the core ports failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* riscPipe.f */
+incdir+logic
logic/riscPipePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/executeUnit.sv
logic/riscPipeCore.sv
testbench/riscPipe_props.sv
testbench/riscPipeTb.sv

/* Bender.yml */
package:
  name: riscPipe

export_include_dirs:
  - logic

sources:
  - logic/riscPipePkg.sv
  - logic/instrDecoder.sv
  - logic/regFile.sv
  - logic/hazardUnit.sv
  - logic/executeUnit.sv
  - logic/riscPipeCore.sv
  - target: test
    files:
      - testbench/riscPipe_props.sv
      - testbench/riscPipeTb.sv
